/* all.f */
verilog/nmea_pkg.sv
verilog/nmea_field_if.sv
verilog/zda_sentence_fsm.sv
verilog/field_position_counter.sv
verilog/ascii_decimal.sv
verilog/zda_time_capture.sv
verilog/axil_zda_regs.sv
verilog/gpzda_top.sv
tests/tb_gpzda.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gpzda -f all.f -o tb_gpzda \
    && ./obj_dir/tb_gpzda > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && exit 0 || exit 1

/* tests/tb_gpzda.sv */
`timescale 1ns/1ps

module tb_gpzda;

    localparam int WAIT_LIMIT = 50;      // cycles allowed for any single handshake.

    logic        clk;
    logic        rst;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [7:0]  tx_q[$];                // bytes of the sentence being sent.
    int          errors = 0;
    int          checks = 0;
    int          exp_good = 0;
    int          exp_bad = 0;

    gpzda_top dut0 (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    // Register words as the host sees them.
    function automatic logic [31:0] time_word(input int hh, input int mm, input int ss);
        return {8'h00, 8'(hh), 8'(mm), 8'(ss)};
    endfunction

    function automatic logic [31:0] date_word(input int dd, input int mo, input int yy);
        return {16'(yy), 8'(mo), 8'(dd)};
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'd48 + {4'd0, n};   // '0' to '9'.
        end
        return 8'd55 + {4'd0, n};       // 'A' to 'F'.
    endfunction

    task automatic put_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            tx_q.push_back(s[i]);
        end
    endtask

    // Appends v as n decimal digits, leading zeros included.
    task automatic put_dec(input int v, input int n);
        int div;
        div = 1;
        for (int i = 1; i < n; i++) begin
            div = div * 10;
        end
        for (int i = 0; i < n; i++) begin
            tx_q.push_back(8'(48 + (v / div) % 10));
            div = div / 10;
        end
    endtask

    task automatic send_queue();
        foreach (tx_q[i]) begin
            rx_data  = tx_q[i];
            rx_valid = 1'b1;
            @(posedge clk);
            #2;
        end
        rx_valid = 1'b0;
        tx_q.delete();
    endtask

    // Builds one complete sentence; the checksum covers everything between '$' and '*'.
    task automatic send_sentence(input string addr, input int hh, input int mm, input int ss,
                                 input int dd, input int mo, input int yy, input bit bad_ck);
        logic [7:0] ck;
        tx_q.delete();
        put_text("$");
        put_text(addr);
        put_text(",");
        put_dec(hh, 2);
        put_dec(mm, 2);
        put_dec(ss, 2);
        put_text(".00,");
        put_dec(dd, 2);
        put_text(",");
        put_dec(mo, 2);
        put_text(",");
        put_dec(yy, 4);
        put_text(",00,00");
        ck = 8'd0;
        for (int i = 1; i < tx_q.size(); i++) begin
            ck = ck ^ tx_q[i];
        end
        if (bad_ck) begin
            ck = ck ^ 8'h5A;
        end
        put_text("*");
        tx_q.push_back(hex_char(ck[7:4]));
        tx_q.push_back(hex_char(ck[3:0]));
        tx_q.push_back(nmea_pkg::CH_CR);
        tx_q.push_back(8'h0A);
        send_queue();
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int t;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        t = 0;
        while (!arready && t < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!arready) begin
            report_timeout("arready");
        end
        @(posedge clk);              // address transfer.
        #2;
        arvalid = 1'b0;
        t = 0;
        while (!rvalid && t < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!rvalid) begin
            report_timeout("rvalid");
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int t;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wvalid  = 1'b1;
        bready  = 1'b1;
        t = 0;
        while (!(awready && wready) && t < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!(awready && wready)) begin
            report_timeout("awready and wready");
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        t = 0;
        while (!bvalid && t < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!bvalid) begin
            report_timeout("bvalid");
        end
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic expect_reg(input logic [4:0] addr, input string name,
                              input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value(name, data, exp);
        check_value({name, " rresp"}, {30'd0, resp}, {30'd0, nmea_pkg::RESP_OKAY});
    endtask

    task automatic expect_time_date(input int hh, input int mm, input int ss,
                                    input int dd, input int mo, input int yy);
        expect_reg(nmea_pkg::REG_TIME, "time", time_word(hh, mm, ss));
        expect_reg(nmea_pkg::REG_DATE, "date", date_word(dd, mo, yy));
    endtask

    task automatic expect_counts();
        expect_reg(nmea_pkg::REG_GOOD, "good_cnt", 32'(exp_good));
        expect_reg(nmea_pkg::REG_BAD, "bad_cnt", 32'(exp_bad));
    endtask

    task automatic test_reset_state();
        expect_reg(nmea_pkg::REG_STATUS, "status", 32'd0);
        expect_counts();
    endtask

    task automatic test_good_sentence();
        send_sentence("GPZDA", 12, 34, 56, 15, 7, 2024, 1'b0);
        exp_good++;
        expect_time_date(12, 34, 56, 15, 7, 2024);
        expect_reg(nmea_pkg::REG_STATUS, "status", 32'd1);
        expect_counts();
    endtask

    task automatic test_bad_checksum();
        send_sentence("GPZDA", 1, 2, 3, 4, 5, 1999, 1'b1);
        exp_bad++;
        expect_time_date(12, 34, 56, 15, 7, 2024);  // still the last good sentence.
        expect_counts();
    endtask

    task automatic test_skipped_sentences();
        send_sentence("GPGGA", 8, 8, 8, 8, 8, 1988, 1'b0);
        expect_time_date(12, 34, 56, 15, 7, 2024);
        expect_counts();
        put_text("$GPZDA,0911");                     // cut short by the next '$'.
        send_queue();
        send_sentence("GPZDA", 9, 11, 30, 28, 2, 2025, 1'b0);
        exp_good++;
        expect_time_date(9, 11, 30, 28, 2, 2025);
        expect_counts();
    endtask

    // Each readback overlaps the next sentence, so the byte stream never pauses.
    task automatic test_back_to_back();
        int hh, mm, ss, dd, mo, yy;
        int p_hh, p_mm, p_ss, p_dd, p_mo, p_yy;
        p_hh = 0;
        p_mm = 0;
        p_ss = 0;
        p_dd = 0;
        p_mo = 0;
        p_yy = 0;
        for (int i = 0; i < 20; i++) begin
            hh = int'($urandom % 24);
            mm = int'($urandom % 60);
            ss = int'($urandom % 60);
            dd = int'($urandom % 31) + 1;
            mo = int'($urandom % 12) + 1;
            yy = int'($urandom % 10000);
            fork
                send_sentence("GPZDA", hh, mm, ss, dd, mo, yy, 1'b0);
                begin
                    if (i > 0) begin
                        expect_time_date(p_hh, p_mm, p_ss, p_dd, p_mo, p_yy);
                    end
                end
            join
            exp_good++;
            p_hh = hh;
            p_mm = mm;
            p_ss = ss;
            p_dd = dd;
            p_mo = mo;
            p_yy = yy;
        end
        expect_time_date(p_hh, p_mm, p_ss, p_dd, p_mo, p_yy);
        expect_counts();
    endtask

    task automatic test_axil_errors();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_write(nmea_pkg::REG_TIME, 32'hDEAD_BEEF, resp);
        check_value("bresp", {30'd0, resp}, {30'd0, nmea_pkg::RESP_SLVERR});
        axil_read(5'h14, data, resp);
        check_value("unmapped rdata", data, 32'd0);
        check_value("unmapped rresp", {30'd0, resp}, {30'd0, nmea_pkg::RESP_SLVERR});
        expect_reg(nmea_pkg::REG_STATUS, "status", 32'd1);
        expect_counts();
    endtask

    initial begin
        rst      = 1'b1;
        rx_data  = 8'd0;
        rx_valid = 1'b0;
        awaddr   = 5'd0;
        awvalid  = 1'b0;
        wdata    = 32'd0;
        wstrb    = 4'd0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = 5'd0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        void'($urandom(90450));
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_state();
        test_good_sentence();
        test_bad_checksum();
        test_skipped_sentences();
        test_back_to_back();
        test_axil_errors();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog/ascii_decimal.sv */
`timescale 1ns/1ps

module ascii_decimal #(
    parameter int DIGITS = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clear,
    input  logic [7:0]                      digit,
    input  logic                            digit_valid,
    output logic [$clog2(10**DIGITS)-1:0]   value
);

    logic [3:0]                          digit_val;
    logic [$clog2(10**DIGITS)+3:0]       next_val;   // room for the times-ten step.

    always_comb begin
        if (digit >= "0" && digit <= "9") begin
            digit_val = 4'(digit - "0");
        end else begin
            digit_val = 4'd0;    // a stray character counts as zero.
        end
    end

    // Most significant digit arrives first, so shift the value one decade up.
    assign next_val = value * 4'd10 + digit_val;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            value <= '0;
        end else if (digit_valid) begin
            value <= next_val[$clog2(10**DIGITS)-1:0];
        end
    end

    // The sentence start that clears the converter never carries a digit.
    a_no_clear_with_digit: assert property (
        @(posedge clk) disable iff (rst) !(clear && digit_valid));

endmodule

/* verilog/axil_zda_regs.sv */
`timescale 1ns/1ps

module axil_zda_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [7:0]  hours,
    input  logic [7:0]  minutes,
    input  logic [7:0]  seconds,
    input  logic [7:0]  day,
    input  logic [7:0]  month,
    input  logic [15:0] year,
    input  logic        valid,
    input  logic        commit,
    input  logic        reject
);

    logic [15:0] good_cnt;
    logic [15:0] bad_cnt;
    logic [31:0] rd_word;
    logic        rd_hit;
    logic        wr_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            good_cnt <= 16'd0;
            bad_cnt  <= 16'd0;
        end else begin
            if (commit) begin
                good_cnt <= good_cnt + 16'd1;
            end
            if (reject) begin
                bad_cnt <= bad_cnt + 16'd1;
            end
        end
    end

    always_comb begin
        rd_hit = 1'b1;
        case (araddr)
            nmea_pkg::REG_TIME:   rd_word = {8'h00, hours, minutes, seconds};
            nmea_pkg::REG_DATE:   rd_word = {year, month, day};
            nmea_pkg::REG_GOOD:   rd_word = {16'h0000, good_cnt};
            nmea_pkg::REG_BAD:    rd_word = {16'h0000, bad_cnt};
            nmea_pkg::REG_STATUS: rd_word = {31'd0, valid};
            default: begin
                rd_word = 32'd0;
                rd_hit  = 1'b0;
            end
        endcase
    end

    // One read in flight at a time.
    assign arready = !rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rd_word;
            rresp <= rd_hit ? nmea_pkg::RESP_OKAY : nmea_pkg::RESP_SLVERR;
        end
    end

    // Address and data are taken together; every register is read-only.
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bresp   = nmea_pkg::RESP_SLVERR;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    a_rdata_hold: assert property (
        @(posedge clk) disable iff (rst) rvalid && !rready |=> $stable(rdata));

endmodule

/* verilog/field_position_counter.sv */
`timescale 1ns/1ps

module field_position_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       in_body,
    nmea_field_if.source fld
);

    logic [nmea_pkg::FIELD_W-1:0] field_cnt;
    logic [nmea_pkg::CHAR_W-1:0]  char_cnt;
    logic                         fwd;

    assign fwd = in_body && rx_valid && (rx_data != nmea_pkg::CH_COMMA);

    // field_idx follows the counter every cycle, so it reads zero between sentences.
    assign fld.field_idx = field_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            field_cnt    <= '0;
            char_cnt     <= '0;
            fld.ch_valid <= 1'b0;
        end else begin
            fld.ch_valid <= fwd;
            if (!in_body) begin
                field_cnt <= '0;
                char_cnt  <= '0;
            end else if (rx_valid && rx_data == nmea_pkg::CH_COMMA) begin
                if (field_cnt != '1) begin
                    field_cnt <= field_cnt + 1'b1;
                end
                char_cnt <= '0;
            end else if (rx_valid && char_cnt != '1) begin
                char_cnt <= char_cnt + 1'b1;  // holds at the top on long fields.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            fld.ch          <= rx_data;
            fld.char_idx    <= char_cnt;
            fld.field_start <= (char_cnt == '0);
        end
    end

endmodule

/* verilog/gpzda_top.sv */
`timescale 1ns/1ps

module gpzda_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic        in_body;
    logic        commit;
    logic        reject;
    logic [7:0]  hours;
    logic [7:0]  minutes;
    logic [7:0]  seconds;
    logic [7:0]  day;
    logic [7:0]  month;
    logic [15:0] year;
    logic        valid;

    nmea_field_if fld_bus ();

    zda_sentence_fsm u_fsm (
        .clk(clk), .rst(rst),
        .rx_data(rx_data), .rx_valid(rx_valid),
        .in_body(in_body), .commit(commit), .reject(reject)
    );

    field_position_counter u_pos (
        .clk(clk), .rst(rst),
        .rx_data(rx_data), .rx_valid(rx_valid),
        .in_body(in_body), .fld(fld_bus.source)
    );

    zda_time_capture u_cap (
        .clk(clk), .rst(rst), .fld(fld_bus.sink), .commit(commit),
        .hours(hours), .minutes(minutes), .seconds(seconds),
        .day(day), .month(month), .year(year), .valid(valid)
    );

    axil_zda_regs u_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .hours(hours), .minutes(minutes), .seconds(seconds),
        .day(day), .month(month), .year(year), .valid(valid),
        .commit(commit), .reject(reject)
    );

endmodule

/* verilog/nmea_field_if.sv */
`timescale 1ns/1ps

interface nmea_field_if;

    logic [7:0]                    ch;           // body character, never a comma.
    logic                          ch_valid;     // high for one cycle per character.
    logic [nmea_pkg::FIELD_W-1:0]  field_idx;    // zero outside a sentence body.
    logic [nmea_pkg::CHAR_W-1:0]   char_idx;     // position inside the field.
    logic                          field_start;  // first character of a field.

    modport source (output ch, ch_valid, field_idx, char_idx, field_start);
    modport sink   (input  ch, ch_valid, field_idx, char_idx, field_start);

endinterface

/* verilog/nmea_pkg.sv */
package nmea_pkg;

    // Framing characters of an NMEA 0183 sentence.
    localparam logic [7:0] CH_DOLLAR = 8'h24;   // starts every sentence.
    localparam logic [7:0] CH_COMMA  = 8'h2C;   // separates the fields.
    localparam logic [7:0] CH_STAR   = 8'h2A;   // precedes the two checksum digits.
    localparam logic [7:0] CH_CR     = 8'h0D;   // ends the sentence.

    // Length of the address field, as in GPZDA.
    localparam int HDR_LEN = 5;

    // Position widths on the field interface.
    localparam int FIELD_W = 3;
    localparam int CHAR_W  = 4;

    // Field indices counted from the address field, which is field 0.
    localparam logic [FIELD_W-1:0] FIELD_TIME  = 3'd1;  // hhmmss.ss
    localparam logic [FIELD_W-1:0] FIELD_DAY   = 3'd2;
    localparam logic [FIELD_W-1:0] FIELD_MONTH = 3'd3;
    localparam logic [FIELD_W-1:0] FIELD_YEAR  = 3'd4;

    // Register byte offsets of the host interface.
    localparam logic [4:0] REG_TIME   = 5'h00;
    localparam logic [4:0] REG_DATE   = 5'h04;
    localparam logic [4:0] REG_GOOD   = 5'h08;
    localparam logic [4:0] REG_BAD    = 5'h0C;
    localparam logic [4:0] REG_STATUS = 5'h10;

    // AXI response codes.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* verilog/zda_sentence_fsm.sv */
`timescale 1ns/1ps

module zda_sentence_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       in_body,
    output logic       commit,
    output logic       reject
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_BODY,
        ST_CK_HI,
        ST_CK_LO
    } state_t;

    state_t     state;
    logic [2:0] hdr_cnt;     // characters of the address field seen so far.
    logic [7:0] xor_sum;     // running checksum over header and body.
    logic [3:0] ck_hi;       // first checksum digit.
    logic       ck_hi_ok;
    logic [4:0] nib;         // valid flag and value of the current hex digit.
    logic       body_end;

    // Returns {is_hex, value} for one ASCII character.
    function automatic logic [4:0] hex_nibble(input logic [7:0] c);
        logic [4:0] r;
        r = 5'd0;
        if (c >= "0" && c <= "9") begin
            r = {1'b1, 4'(c - "0")};
        end else if (c >= "A" && c <= "F") begin
            r = {1'b1, 4'(c - "A" + 8'd10)};
        end else if (c >= "a" && c <= "f") begin
            r = {1'b1, 4'(c - "a" + 8'd10)};
        end
        return r;
    endfunction

    function automatic logic [7:0] hdr_char(input logic [2:0] idx);
        case (idx)
            3'd0:    return "G";
            3'd1:    return "P";
            3'd2:    return "Z";
            3'd3:    return "D";
            default: return "A";
        endcase
    endfunction

    assign nib = hex_nibble(rx_data);

    assign body_end = rx_valid && (rx_data == nmea_pkg::CH_STAR ||
                                   rx_data == nmea_pkg::CH_DOLLAR ||
                                   rx_data == nmea_pkg::CH_CR);

    // The terminating byte itself is not part of the body.
    assign in_body = (state == ST_BODY) && !body_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            hdr_cnt <= 3'd0;
            xor_sum <= 8'd0;
            commit  <= 1'b0;
            reject  <= 1'b0;
        end else begin
            commit <= 1'b0;
            reject <= 1'b0;
            if (rx_valid) begin
                if (rx_data == nmea_pkg::CH_DOLLAR) begin
                    state   <= ST_HEADER;  // restart from any state.
                    hdr_cnt <= 3'd0;
                    xor_sum <= 8'd0;
                end else begin
                    case (state)
                        ST_HEADER: begin
                            xor_sum <= xor_sum ^ rx_data;
                            hdr_cnt <= hdr_cnt + 3'd1;
                            if (rx_data != hdr_char(hdr_cnt)) begin
                                state <= ST_IDLE;   // another sentence type is skipped.
                            end else if (hdr_cnt == 3'(nmea_pkg::HDR_LEN - 1)) begin
                                state <= ST_BODY;
                            end
                        end
                        ST_BODY: begin
                            if (rx_data == nmea_pkg::CH_STAR) begin
                                state <= ST_CK_HI;
                            end else if (rx_data == nmea_pkg::CH_CR) begin
                                state <= ST_IDLE;   // no checksum, nothing to decide.
                            end else begin
                                xor_sum <= xor_sum ^ rx_data;
                            end
                        end
                        ST_CK_HI: begin
                            state <= ST_CK_LO;
                        end
                        ST_CK_LO: begin
                            state <= ST_IDLE;
                            if (ck_hi_ok && nib[4] && {ck_hi, nib[3:0]} == xor_sum) begin
                                commit <= 1'b1;
                            end else begin
                                reject <= 1'b1;
                            end
                        end
                        default: begin
                            state <= ST_IDLE;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == ST_CK_HI) begin
            ck_hi    <= nib[3:0];
            ck_hi_ok <= nib[4];
        end
    end

    a_commit_reject_excl: assert property (
        @(posedge clk) disable iff (rst) !(commit && reject));

endmodule

/* verilog/zda_time_capture.sv */
`timescale 1ns/1ps

module zda_time_capture (
    input  logic        clk,
    input  logic        rst,
    nmea_field_if.sink  fld,
    input  logic        commit,
    output logic [7:0]  hours,
    output logic [7:0]  minutes,
    output logic [7:0]  seconds,
    output logic [7:0]  day,
    output logic [7:0]  month,
    output logic [15:0] year,
    output logic        valid
);

    logic [4:0]  en2;           // hours, minutes, seconds, day, month.
    logic        en_year;
    logic [6:0]  val2 [5];
    logic [13:0] year_val;
    logic        body_q;
    logic        clear;
    logic        time_seen;

    // First cycle after the opening comma, before any digit of the sentence.
    assign clear = (fld.field_idx != '0) && !body_q;

    always_comb begin
        en2     = 5'd0;
        en_year = 1'b0;
        if (fld.ch_valid) begin
            case (fld.field_idx)
                nmea_pkg::FIELD_TIME: begin
                    if (fld.char_idx < 4'd6) begin
                        en2[fld.char_idx[2:1]] = 1'b1;  // two characters per unit.
                    end
                end
                nmea_pkg::FIELD_DAY:   en2[3]  = (fld.char_idx < 4'd2);
                nmea_pkg::FIELD_MONTH: en2[4]  = (fld.char_idx < 4'd2);
                nmea_pkg::FIELD_YEAR:  en_year = (fld.char_idx < 4'd4);
                default: ;
            endcase
        end
    end

    for (genvar i = 0; i < 5; i++) begin : g_two_digit
        ascii_decimal #(.DIGITS(2)) u_conv (
            .clk(clk), .rst(rst), .clear(clear),
            .digit(fld.ch), .digit_valid(en2[i]), .value(val2[i])
        );
    end

    ascii_decimal #(.DIGITS(4)) u_year (
        .clk(clk), .rst(rst), .clear(clear),
        .digit(fld.ch), .digit_valid(en_year), .value(year_val)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            body_q    <= 1'b0;
            time_seen <= 1'b0;
        end else begin
            body_q <= (fld.field_idx != '0);
            if (clear) begin
                time_seen <= 1'b0;
            end else if (fld.ch_valid && fld.field_start &&
                         fld.field_idx == nmea_pkg::FIELD_TIME) begin
                time_seen <= 1'b1;
            end
        end
    end

    // A receiver without a fix sends empty fields; those leave the outputs alone.
    always_ff @(posedge clk) begin
        if (rst) begin
            hours   <= 8'd0;
            minutes <= 8'd0;
            seconds <= 8'd0;
            day     <= 8'd0;
            month   <= 8'd0;
            year    <= 16'd0;
            valid   <= 1'b0;
        end else if (commit && time_seen) begin
            hours   <= {1'b0, val2[0]};
            minutes <= {1'b0, val2[1]};
            seconds <= {1'b0, val2[2]};
            day     <= {1'b0, val2[3]};
            month   <= {1'b0, val2[4]};
            year    <= {2'b00, year_val};
            valid   <= 1'b1;
        end
    end

endmodule
